/* decode_pkg.sv */
package decode_pkg;

    // register numbers and segment selectors
    typedef logic [2:0] gpr_idx_t;
    typedef logic [2:0] sreg_idx_t;
    // displacement after sign extension
    typedef logic [31:0] disp_t;

    // general registers, 32-bit names
    localparam gpr_idx_t GPR_EAX = 3'd0;
    localparam gpr_idx_t GPR_ECX = 3'd1;
    localparam gpr_idx_t GPR_EDX = 3'd2;
    localparam gpr_idx_t GPR_EBX = 3'd3;
    localparam gpr_idx_t GPR_ESP = 3'd4;
    localparam gpr_idx_t GPR_EBP = 3'd5;
    localparam gpr_idx_t GPR_ESI = 3'd6;
    localparam gpr_idx_t GPR_EDI = 3'd7;

    // segment registers
    localparam sreg_idx_t SREG_ES = 3'd0;
    localparam sreg_idx_t SREG_CS = 3'd1;
    localparam sreg_idx_t SREG_SS = 3'd2;
    localparam sreg_idx_t SREG_DS = 3'd3;
    localparam sreg_idx_t SREG_FS = 3'd4;
    localparam sreg_idx_t SREG_GS = 3'd5;

    // byte lanes of the displacement register
    localparam int DISP_LANES = 4;

    // mod r/m byte, msb first
    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
    } modrm_t;

    // s-i-b byte, msb first
    typedef struct packed {
        logic [1:0] ss;
        gpr_idx_t   index;
        gpr_idx_t   base;
    } sib_t;

    // address mode before the displacement is known
    typedef struct packed {
        logic       is_reg;
        gpr_idx_t   reg_index;
        sreg_idx_t  seg;
        logic       base_present;
        gpr_idx_t   base;
        logic       index_present;
        gpr_idx_t   index;
        logic [1:0] scale;
        logic       sib_present;
        logic [2:0] disp_bytes;
    } addr_mode_t;

    // effective-address descriptor at the stage output
    typedef struct packed {
        logic       is_reg;
        gpr_idx_t   reg_index;
        sreg_idx_t  seg;
        logic       base_present;
        gpr_idx_t   base;
        logic       index_present;
        gpr_idx_t   index;
        logic [1:0] scale;
        disp_t      disp;
    } ea_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DISPATCH,
        ST_SIB,
        ST_DISP,
        ST_DONE
    } addr_state_t;

endpackage

/* decode_mod_rm.sv */
`timescale 1ns/1ps

module decode_mod_rm
    import decode_pkg::*;
(
    input  modrm_t     i_modrm,
    input  logic       i_addr_size_32,
    output addr_mode_t o_mode
);

    // one-hot mod field
    logic mod_00;
    logic mod_01;
    logic mod_10;
    logic mod_11;
    // one-hot r/m field
    logic rm_000;
    logic rm_001;
    logic rm_010;
    logic rm_011;
    logic rm_100;
    logic rm_101;
    logic rm_110;
    logic rm_111;
    logic size_16;
    logic size_32;
    // 16-bit table terms
    logic base_bx_16;
    logic base_bp_16;
    logic index_si_16;
    logic index_di_16;
    logic direct_16;
    // 32-bit table terms
    logic sib_32;
    logic direct_32;
    logic base_rm_32;
    // final selects
    logic use_bx;
    logic use_bp;
    logic use_rm;
    logic use_si;
    logic use_di;
    logic seg_ss;
    logic seg_ds;
    logic disp_1;
    logic disp_2;
    logic disp_4;

    assign mod_00 = (i_modrm.mod == 2'b00);
    assign mod_01 = (i_modrm.mod == 2'b01);
    assign mod_10 = (i_modrm.mod == 2'b10);
    assign mod_11 = (i_modrm.mod == 2'b11);

    assign rm_000 = (i_modrm.rm == 3'b000);
    assign rm_001 = (i_modrm.rm == 3'b001);
    assign rm_010 = (i_modrm.rm == 3'b010);
    assign rm_011 = (i_modrm.rm == 3'b011);
    assign rm_100 = (i_modrm.rm == 3'b100);
    assign rm_101 = (i_modrm.rm == 3'b101);
    assign rm_110 = (i_modrm.rm == 3'b110);
    assign rm_111 = (i_modrm.rm == 3'b111);

    assign size_32 = i_addr_size_32;
    assign size_16 = ~i_addr_size_32;

    // bx+si, bx+di, bx
    assign base_bx_16  = ~mod_11 & (rm_000 | rm_001 | rm_111);
    // bp+si, bp+di, and bp+disp only when mod is 01 or 10
    assign base_bp_16  = (~mod_11 & (rm_010 | rm_011)) | ((mod_01 | mod_10) & rm_110);
    assign index_si_16 = ~mod_11 & (rm_000 | rm_010 | rm_100);
    assign index_di_16 = ~mod_11 & (rm_001 | rm_011 | rm_101);
    // [disp16], no registers at all
    assign direct_16   = mod_00 & rm_110;

    // r/m=100 escapes to the s-i-b byte
    assign sib_32     = ~mod_11 & rm_100;
    // [disp32], no base
    assign direct_32  = mod_00 & rm_101;
    assign base_rm_32 = ~mod_11 & ~rm_100 & ~direct_32;

    assign use_bx = size_16 & base_bx_16;
    assign use_bp = size_16 & base_bp_16;
    assign use_rm = size_32 & base_rm_32;
    assign use_si = size_16 & index_si_16;
    assign use_di = size_16 & index_di_16;

    // ss whenever bp or ebp is the base
    assign seg_ss = use_bp | (use_rm & rm_101);
    assign seg_ds = ~seg_ss;

    assign disp_1 = mod_01;
    assign disp_2 = size_16 & (mod_10 | direct_16);
    assign disp_4 = size_32 & (mod_10 | direct_32);

    always_comb begin
        o_mode = '0;

        // register operand ignores every memory field
        o_mode.is_reg    = mod_11;
        o_mode.reg_index = i_modrm.rm;

        unique case (1'b1)
            seg_ss:  o_mode.seg = SREG_SS;
            seg_ds:  o_mode.seg = SREG_DS;
            default: o_mode.seg = SREG_DS;
        endcase

        unique case (1'b1)
            use_bx:  o_mode.base = GPR_EBX;
            use_bp:  o_mode.base = GPR_EBP;
            use_rm:  o_mode.base = i_modrm.rm;
            default: o_mode.base = GPR_EAX;
        endcase
        o_mode.base_present = use_bx | use_bp | use_rm;

        // 32-bit index only ever comes from the s-i-b byte
        unique case (1'b1)
            use_si:  o_mode.index = GPR_ESI;
            use_di:  o_mode.index = GPR_EDI;
            default: o_mode.index = GPR_EAX;
        endcase
        o_mode.index_present = use_si | use_di;

        o_mode.scale       = 2'd0;
        o_mode.sib_present = size_32 & sib_32;

        unique case (1'b1)
            disp_1:  o_mode.disp_bytes = 3'd1;
            disp_2:  o_mode.disp_bytes = 3'd2;
            disp_4:  o_mode.disp_bytes = 3'd4;
            default: o_mode.disp_bytes = 3'd0;
        endcase
    end

endmodule

/* decode_sib.sv */
`timescale 1ns/1ps

module decode_sib
    import decode_pkg::*;
(
    input  addr_mode_t i_mode,
    input  sib_t       i_sib,
    input  logic [1:0] i_mod,
    output addr_mode_t o_mode
);

    // index field 100 means no index
    logic no_index;
    // base field 101 under mod=00 means disp32 only
    logic no_base;
    logic base_stack;

    assign no_index   = (i_sib.index == GPR_ESP);
    assign no_base    = (i_mod == 2'b00) && (i_sib.base == GPR_EBP);
    // esp or ebp as base selects the stack segment
    assign base_stack = !no_base && ((i_sib.base == GPR_ESP) || (i_sib.base == GPR_EBP));

    always_comb begin
        o_mode = i_mode;
        if (i_mode.sib_present) begin
            o_mode.base_present  = !no_base;
            o_mode.base          = no_base ? GPR_EAX : i_sib.base;
            o_mode.index_present = !no_index;
            o_mode.index         = no_index ? GPR_EAX : i_sib.index;
            o_mode.scale         = i_sib.ss;
            o_mode.seg           = base_stack ? SREG_SS : SREG_DS;
            // mod=00 gives no displacement unless the base is dropped
            if (no_base) begin
                o_mode.disp_bytes = 3'd4;
            end
        end
    end

endmodule

/* decode_disp_counter.sv */
`timescale 1ns/1ps

module decode_disp_counter (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_load,
    input  logic [2:0] i_count,
    input  logic       i_take,
    output logic [1:0] o_lane,
    output logic       o_last
);

    // bytes still expected
    logic [2:0] count;
    // lane of the next byte, lsb first
    logic [1:0] lane;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            count <= 3'd0;
            lane  <= 2'd0;
        end else if (i_load) begin
            count <= i_count;
            lane  <= 2'd0;
        end else if (i_take && (count != 3'd0)) begin
            count <= count - 3'd1;
            // wraps after lane 3, count is zero by then
            lane  <= lane + 2'd1;
        end
    end

    assign o_lane = lane;
    assign o_last = (count == 3'd1);

endmodule

/* decode_disp_assemble.sv */
`timescale 1ns/1ps

module decode_disp_assemble
    import decode_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_clear,
    input  logic       i_take,
    input  logic [1:0] i_lane,
    input  logic [7:0] i_byte,
    output disp_t      o_disp
);

    disp_t disp;
    disp_t disp_next;

    // byte into its lane, sign copied into every lane above
    always_comb begin
        disp_next = disp;
        for (int k = 0; k < DISP_LANES; k++) begin
            if (k == int'(i_lane)) begin
                disp_next[8*k +: 8] = i_byte;
            end else if (k > int'(i_lane)) begin
                disp_next[8*k +: 8] = {8{i_byte[7]}};
            end
        end
    end

    // lower lanes were written by earlier bytes and stay as they are
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            disp <= '0;
        end else if (i_clear) begin
            disp <= '0;
        end else if (i_take) begin
            disp <= disp_next;
        end
    end

    assign o_disp = disp;

endmodule

/* decode_addr_fsm.sv */
`timescale 1ns/1ps

module decode_addr_fsm
    import decode_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_byte_valid,
    input  logic [7:0] i_byte,
    input  addr_mode_t i_mode,
    input  logic       i_last,
    output modrm_t     o_modrm,
    output sib_t       o_sib,
    output logic       o_load,
    output logic       o_take_disp,
    output logic       o_clear,
    output logic       o_expect_byte,
    output logic       o_ea_valid
);

    addr_state_t state;
    addr_state_t state_next;
    // s-i-b byte already in for this operand
    logic        sib_taken;
    logic        ea_valid_q;
    modrm_t      modrm_q;
    sib_t        sib_q;
    logic        take_modrm;
    logic        take_sib;

    // idle is blocked for the cycle of the output pulse
    assign o_expect_byte = ((state == ST_IDLE) && !ea_valid_q) ||
                           (state == ST_SIB) || (state == ST_DISP);

    assign take_modrm  = (state == ST_IDLE) && !ea_valid_q && i_byte_valid;
    assign take_sib    = (state == ST_SIB) && i_byte_valid;
    assign o_take_disp = (state == ST_DISP) && i_byte_valid;
    assign o_clear     = take_modrm;

    always_comb begin
        state_next = state;
        o_load     = 1'b0;
        unique case (state)
            ST_IDLE: begin
                if (take_modrm) begin
                    state_next = ST_DISPATCH;
                end
            end
            ST_DISPATCH: begin
                if (i_mode.sib_present && !sib_taken) begin
                    state_next = ST_SIB;
                end else if (i_mode.disp_bytes != 3'd0) begin
                    // counter output ready on the first ST_DISP cycle
                    o_load     = 1'b1;
                    state_next = ST_DISP;
                end else begin
                    state_next = ST_DONE;
                end
            end
            ST_SIB: begin
                // back through dispatch, the s-i-b byte can change disp size
                if (take_sib) begin
                    state_next = ST_DISPATCH;
                end
            end
            ST_DISP: begin
                if (o_take_disp && i_last) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            sib_taken  <= 1'b0;
            ea_valid_q <= 1'b0;
        end else begin
            state      <= state_next;
            // one pulse per descriptor
            ea_valid_q <= (state == ST_DONE);
            if (take_modrm) begin
                sib_taken <= 1'b0;
            end else if (take_sib) begin
                sib_taken <= 1'b1;
            end
        end
    end

    // operand bytes
    always_ff @(posedge i_clk) begin
        if (take_modrm) begin
            modrm_q <= modrm_t'(i_byte);
        end
        if (take_sib) begin
            sib_q <= sib_t'(i_byte);
        end
    end

    assign o_modrm    = modrm_q;
    assign o_sib      = sib_q;
    assign o_ea_valid = ea_valid_q;

endmodule

/* decode_addr_stage.sv */
`timescale 1ns/1ps

module decode_addr_stage
    import decode_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_byte_valid,
    input  logic [7:0] i_byte,
    input  logic       i_addr_size_32,
    output logic       o_expect_byte,
    output logic       o_ea_valid,
    output ea_t        o_ea
);

    modrm_t     modrm;
    sib_t       sib;
    addr_mode_t mode_rm;
    addr_mode_t mode;
    logic       load;
    logic       take_disp;
    logic       clear;
    logic [1:0] lane;
    logic       last;
    disp_t      disp;
    // address size latched with the mod r/m byte
    logic       size_32_q;
    ea_t        ea_new;
    ea_t        ea_q;

    always_ff @(posedge i_clk) begin
        if (clear) begin
            size_32_q <= i_addr_size_32;
        end
    end

    decode_addr_fsm u_decode_addr_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_byte_valid  (i_byte_valid),
        .i_byte        (i_byte),
        .i_mode        (mode),
        .i_last        (last),
        .o_modrm       (modrm),
        .o_sib         (sib),
        .o_load        (load),
        .o_take_disp   (take_disp),
        .o_clear       (clear),
        .o_expect_byte (o_expect_byte),
        .o_ea_valid    (o_ea_valid)
    );

    decode_mod_rm u_decode_mod_rm (
        .i_modrm        (modrm),
        .i_addr_size_32 (size_32_q),
        .o_mode         (mode_rm)
    );

    decode_sib u_decode_sib (
        .i_mode (mode_rm),
        .i_sib  (sib),
        .i_mod  (modrm.mod),
        .o_mode (mode)
    );

    decode_disp_counter u_decode_disp_counter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_load  (load),
        .i_count (mode.disp_bytes),
        .i_take  (take_disp),
        .o_lane  (lane),
        .o_last  (last)
    );

    decode_disp_assemble u_decode_disp_assemble (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (clear),
        .i_take  (take_disp),
        .i_lane  (lane),
        .i_byte  (i_byte),
        .o_disp  (disp)
    );

    // descriptor from the final mode and the assembled displacement
    always_comb begin
        ea_new.is_reg        = mode.is_reg;
        ea_new.reg_index     = mode.reg_index;
        ea_new.seg           = mode.seg;
        ea_new.base_present  = mode.base_present;
        ea_new.base          = mode.base;
        ea_new.index_present = mode.index_present;
        ea_new.index         = mode.index;
        ea_new.scale         = mode.scale;
        ea_new.disp          = disp;
    end

    // keeps the last descriptor after the pulse
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ea_q <= '0;
        end else if (o_ea_valid) begin
            ea_q <= ea_new;
        end
    end

    assign o_ea = o_ea_valid ? ea_new : ea_q;

endmodule

/* decode_addr_assertions.sv */
`timescale 1ns/1ps

module decode_addr_assertions
    import decode_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input logic i_expect_byte,
    input logic i_ea_valid,
    input ea_t  i_ea
);

    // failures so far, watched by the testbench
    int fail_count = 0;

    // descriptor pulse lasts one cycle
    property p_valid_single;
        @(posedge i_clk) disable iff (!i_rst_n)
        i_ea_valid |=> !i_ea_valid;
    endproperty

    property p_ea_known;
        @(posedge i_clk) disable iff (!i_rst_n)
        i_ea_valid |-> !$isunknown(i_ea);
    endproperty

    // no byte accepted in the pulse cycle
    property p_no_expect_on_valid;
        @(posedge i_clk) disable iff (!i_rst_n)
        i_ea_valid |-> !i_expect_byte;
    endproperty

    // state right after a reset edge
    property p_reset_state;
        @(posedge i_clk)
        !i_rst_n |=> (!i_ea_valid && i_expect_byte);
    endproperty

    a_valid_single: assert property (p_valid_single)
    else begin
        $error("o_ea_valid stayed high for more than one cycle");
        fail_count++;
    end

    a_ea_known: assert property (p_ea_known)
    else begin
        $error("o_ea has unknown bits while o_ea_valid is high");
        fail_count++;
    end

    a_no_expect_on_valid: assert property (p_no_expect_on_valid)
    else begin
        $error("o_expect_byte high during the o_ea_valid pulse");
        fail_count++;
    end

    a_reset_state: assert property (p_reset_state)
    else begin
        $error("wrong o_ea_valid or o_expect_byte after reset");
        fail_count++;
    end

endmodule

bind decode_addr_stage decode_addr_assertions u_decode_addr_assertions (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_expect_byte (o_expect_byte),
    .i_ea_valid    (o_ea_valid),
    .i_ea          (o_ea)
);

/* tb_decode_addr_stage.sv */
`timescale 1ns/1ps

module tb_decode_addr_stage
    import decode_pkg::*;
();

    localparam int TIMEOUT = 40;

    logic        clk;
    logic        rst_n;
    logic        byte_valid;
    logic [7:0]  byte_in;
    logic        addr_size_32;
    logic        expect_byte;
    logic        ea_valid;
    ea_t         ea;
    integer      seed;
    // random idle cycles between bytes
    logic        jitter;
    // strobe bytes while the stage is busy
    logic        junk_en;
    logic [7:0]  rnd;
    logic [7:0]  sib_b;
    logic [31:0] raw;

    decode_addr_stage u_decode_addr_stage (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_byte_valid   (byte_valid),
        .i_byte         (byte_in),
        .i_addr_size_32 (addr_size_32),
        .o_expect_byte  (expect_byte),
        .o_ea_valid     (ea_valid),
        .o_ea           (ea)
    );

    always #5 clk = ~clk;

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // bound protocol checks
    always @(negedge clk) begin
        if (u_decode_addr_stage.u_decode_addr_assertions.fail_count != 0) begin
            stop_fail("a bound protocol assertion failed");
        end
    end

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] act);
        assert (act === want)
        else begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, want, act);
            stop_fail("descriptor field mismatch");
        end
    endtask

    task automatic check_ea(input ea_t want);
        check_field("is_reg", 32'(want.is_reg), 32'(ea.is_reg));
        check_field("reg_index", 32'(want.reg_index), 32'(ea.reg_index));
        check_field("seg", 32'(want.seg), 32'(ea.seg));
        check_field("base_present", 32'(want.base_present), 32'(ea.base_present));
        check_field("base", 32'(want.base), 32'(ea.base));
        check_field("index_present", 32'(want.index_present), 32'(ea.index_present));
        check_field("index", 32'(want.index), 32'(ea.index));
        check_field("scale", 32'(want.scale), 32'(ea.scale));
        check_field("disp", want.disp, ea.disp);
    endtask

    // expected descriptor from the address-mode tables
    task automatic model(input logic size32, input logic [7:0] m, input logic [7:0] s,
                         input logic [31:0] r, output ea_t want, output logic need_sib,
                         output int nd);
        logic [1:0] md;
        logic [2:0] rm;
        logic       nobase;
        md       = m[7:6];
        rm       = m[2:0];
        want     = '0;
        need_sib = 1'b0;
        nd       = 0;
        nobase   = 1'b0;
        // r/m always shows up in reg_index
        want.reg_index = rm;
        want.seg       = SREG_DS;
        want.is_reg    = (md == 2'b11);
        if (md != 2'b11 && !size32) begin
            nd = (md == 2'b01) ? 1 : ((md == 2'b10 || rm == 3'd6) ? 2 : 0);
            // bx+si bx+di bp+si bp+di si di bp bx
            want.base_present = (rm != 3'd4) && (rm != 3'd5) && !(rm == 3'd6 && md == 2'b00);
            if (want.base_present) begin
                want.base = (rm == 3'd2 || rm == 3'd3 || rm == 3'd6) ? GPR_EBP : GPR_EBX;
            end
            want.index_present = (rm < 3'd6);
            if (want.index_present) begin
                want.index = rm[0] ? GPR_EDI : GPR_ESI;
            end
        end else if (md != 2'b11 && rm == 3'd4) begin
            need_sib           = 1'b1;
            nobase             = (md == 2'b00) && (s[2:0] == 3'd5);
            want.scale         = s[7:6];
            want.index_present = (s[5:3] != 3'd4);
            want.index         = want.index_present ? s[5:3] : GPR_EAX;
            want.base_present  = !nobase;
            want.base          = nobase ? GPR_EAX : s[2:0];
            nd = (md == 2'b01) ? 1 : ((md == 2'b10 || nobase) ? 4 : 0);
        end else if (md != 2'b11) begin
            // [disp32] with no base
            nobase            = (md == 2'b00) && (rm == 3'd5);
            want.base_present = !nobase;
            want.base         = nobase ? GPR_EAX : rm;
            nd = (md == 2'b01) ? 1 : ((md == 2'b10 || nobase) ? 4 : 0);
        end
        // stack segment when esp or ebp (bp) is the base
        if (want.base_present && (want.base == GPR_ESP || want.base == GPR_EBP)) begin
            want.seg = SREG_SS;
        end
        case (nd)
            1: want.disp = {{24{r[7]}}, r[7:0]};
            2: want.disp = {{16{r[15]}}, r[15:0]};
            4: want.disp = r;
            default: want.disp = '0;
        endcase
    endtask

    task automatic idle_cycle();
        byte_valid = junk_en && !expect_byte;
        byte_in    = 8'($random(seed));
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        int waited;
        gap    = jitter ? ($random(seed) & 3) : 0;
        waited = 0;
        repeat (gap) begin
            idle_cycle();
        end
        while (!expect_byte && waited < TIMEOUT) begin
            idle_cycle();
            waited++;
        end
        if (!expect_byte) begin
            stop_fail("timeout: the stage never asked for the next byte");
        end else begin
            byte_valid = 1'b1;
            byte_in    = b;
            @(posedge clk);
            #1;
            byte_valid = 1'b0;
        end
    endtask

    task automatic wait_ea(input ea_t want);
        int waited;
        waited = 0;
        while (!ea_valid && waited < TIMEOUT) begin
            idle_cycle();
            waited++;
        end
        if (!ea_valid) begin
            stop_fail("timeout: o_ea_valid never pulsed");
        end else begin
            byte_valid = 1'b0;
            check_ea(want);
            @(posedge clk);
            #1;
            // held after the pulse
            check_ea(want);
        end
    endtask

    task automatic run_op(input logic size32, input logic [7:0] m, input logic [7:0] s,
                          input logic [31:0] r);
        ea_t  want;
        logic need_sib;
        int   nd;
        model(size32, m, s, r, want, need_sib, nd);
        addr_size_32 = size32;
        send_byte(m);
        // size is latched with the mod r/m byte
        addr_size_32 = !size32;
        if (need_sib) begin
            send_byte(s);
        end
        for (int k = 0; k < nd; k++) begin
            send_byte(r[8*k +: 8]);
        end
        wait_ea(want);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        byte_valid   = 1'b0;
        byte_in      = 8'h00;
        addr_size_32 = 1'b0;
        seed         = 41;
        jitter       = 1'b0;
        junk_en      = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_ea('0);

        // every mod and r/m of the 16-bit table
        for (int md = 0; md < 4; md++) begin
            for (int rm = 0; rm < 8; rm++) begin
                rnd = 8'($random(seed));
                raw = $random(seed);
                run_op(1'b0, {md[1:0], rnd[5:3], rm[2:0]}, 8'h00, raw);
            end
        end

        // 32-bit table without s-i-b
        for (int md = 0; md < 4; md++) begin
            for (int rm = 0; rm < 8; rm++) begin
                rnd = 8'($random(seed));
                raw = $random(seed);
                if (md == 3 || rm != 4) begin
                    run_op(1'b1, {md[1:0], rnd[5:3], rm[2:0]}, 8'h00, raw);
                end
            end
        end

        // s-i-b under each memory mod with the first three in the special forms
        for (int md = 0; md < 3; md++) begin
            for (int n = 0; n < 8; n++) begin
                rnd   = 8'($random(seed));
                sib_b = 8'($random(seed));
                raw   = $random(seed);
                if (n == 0) begin
                    sib_b[5:3] = 3'b100;
                end else if (n == 1) begin
                    sib_b[2:0] = 3'b101;
                end else if (n == 2) begin
                    sib_b[5:0] = 6'b100101;
                end
                run_op(1'b1, {md[1:0], rnd[5:3], 3'b100}, sib_b, raw);
            end
        end

        // 1, 2 and 4 byte displacements with gaps
        jitter = 1'b1;
        for (int n = 0; n < 40; n++) begin
            rnd   = 8'($random(seed));
            sib_b = 8'($random(seed));
            raw   = $random(seed);
            run_op(rnd[6], {(rnd[7] ? 2'b10 : 2'b01), rnd[5:0]}, sib_b, raw);
        end

        // register operands with stray strobes while busy
        junk_en = 1'b1;
        for (int sz = 0; sz < 2; sz++) begin
            for (int rm = 0; rm < 8; rm++) begin
                rnd = 8'($random(seed));
                raw = $random(seed);
                run_op(sz[0], {2'b11, rnd[5:3], rm[2:0]}, 8'h00, raw);
            end
        end
        for (int n = 0; n < 12; n++) begin
            rnd   = 8'($random(seed));
            sib_b = 8'($random(seed));
            raw   = $random(seed);
            run_op(rnd[7], {rnd[6:5], rnd[5:0]}, sib_b, raw);
        end

        if (u_decode_addr_stage.u_decode_addr_assertions.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_fail("bound protocol assertions failed");
        end
    end

endmodule

/* sim.f */
decode_pkg.sv
decode_mod_rm.sv
decode_sib.sv
decode_disp_counter.sv
decode_disp_assemble.sv
decode_addr_fsm.sv
decode_addr_stage.sv
decode_addr_assertions.sv
tb_decode_addr_stage.sv

/* Makefile */
TOP = tb_decode_addr_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
